//--- cnu_c2v_gen.sv
`timescale 1ns/10ps

module cnu_c2v_gen (
	input  logic                    read_clk,
	input  logic                    rstn,
	input  row_pipe_pkg::min_pair_t min_info,
	output row_pipe_pkg::row_msg_t  c2v       // stage 4, extrinsic c2v row
);
	import row_pipe_pkg::*;

	row_msg_t c2v_d;

	// extrinsic message leaves the position's own contribution out
	// sign: product of the other nine signs
	// mag: min over the other nine, i.e. min2 where this position holds min1
	always_comb begin
		for (int i = 0; i < CN_DEGREE; i++) begin
			c2v_d[i].sign = min_info.sign_prod ^ min_info.signs[i];
			if (min_info.min1_idx == IDX_W'(i)) begin
				c2v_d[i].mag = min_info.min2;
			end else begin
				c2v_d[i].mag = min_info.min1;
			end
		end
	end

	// zero magnitude still gets a sign, no special case
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			c2v <= '0;
		end else begin
			c2v <= c2v_d; // whole row at once
		end
	end

endmodule

//--- cnu_min_find.sv
`timescale 1ns/10ps

module cnu_min_find (
	input  logic                    read_clk,
	input  logic                    rstn,
	input  logic                    v2c_src,  // 1: channel row, 0: v2c row
	input  row_pipe_pkg::row_msg_t  ch_msg,
	input  row_pipe_pkg::row_msg_t  v2c_in,
	output row_pipe_pkg::row_msg_t  v2c_row,  // stage 1, also feeds the delay line
	output row_pipe_pkg::min_pair_t min_info  // stage 3
);
	import ldpc_msg_pkg::*;
	import row_pipe_pkg::*;

	// two smallest magnitudes of one half, strict compare keeps the lowest index
	function automatic half_min_t find_half(input row_msg_t row, input int base);
		half_min_t           res;
		logic [MAG_SIZE-1:0] m;
		res.min1     = MAG_SIZE'(MAG_MAX);
		res.min2     = MAG_SIZE'(MAG_MAX);
		res.min1_idx = IDX_W'(base); // all-max half still points at its first slot
		for (int i = 0; i < HALF_DEG; i++) begin
			m = row[base + i].mag;
			if (m < res.min1) begin
				res.min2     = res.min1; // old min drops to second place
				res.min1     = m;
				res.min1_idx = IDX_W'(base + i);
			end else if (m < res.min2) begin
				res.min2 = m; // an equal value lands here too, so ties give min2 == min1
			end
		end
		return res;
	endfunction

	row_msg_t             row_sel;
	half_min_t            half_lo, half_hi;     // stage 2 inputs
	half_min_t            half_lo_q, half_hi_q; // stage 2 regs
	logic [CN_DEGREE-1:0] row_signs;
	logic [CN_DEGREE-1:0] signs_q;              // travels alongside the half minima
	min_pair_t            merged;

	assign row_sel = v2c_src ? ch_msg : v2c_in; // source picked on the sampling edge

	// stage 1, input register
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			v2c_row <= '0;
		end else begin
			v2c_row <= row_sel;
		end
	end

	assign half_lo = find_half(v2c_row, 0);
	assign half_hi = find_half(v2c_row, HALF_DEG);

	always_comb begin
		for (int i = 0; i < CN_DEGREE; i++) begin
			row_signs[i] = v2c_row[i].sign;
		end
	end

	// stage 2, half row minima
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			half_lo_q <= '0;
			half_hi_q <= '0;
			signs_q   <= '0;
		end else begin
			half_lo_q <= half_lo;
			half_hi_q <= half_hi;
			signs_q   <= row_signs;
		end
	end

	// merge halves, low half wins a tie so the index stays the lowest one
	always_comb begin
		merged = '0;
		if (half_lo_q.min1 <= half_hi_q.min1) begin
			merged.min1     = half_lo_q.min1;
			merged.min1_idx = half_lo_q.min1_idx;
			merged.min2     = (half_hi_q.min1 < half_lo_q.min2) ? half_hi_q.min1
				: half_lo_q.min2;
		end else begin
			merged.min1     = half_hi_q.min1;
			merged.min1_idx = half_hi_q.min1_idx;
			merged.min2     = (half_lo_q.min1 < half_hi_q.min2) ? half_lo_q.min1
				: half_hi_q.min2;
		end
		merged.sign_prod = ^signs_q;
		merged.signs     = signs_q;
	end

	// stage 3
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			min_info <= '0;
		end else begin
			min_info <= merged;
		end
	end

endmodule

//--- ldpc_msg_pkg.sv
package ldpc_msg_pkg;

	// message word format, 4-bit sign-magnitude
	localparam int QUAN_SIZE = 4;              // full message width
	localparam int MAG_SIZE  = QUAN_SIZE - 1;  // magnitude part
	localparam int MAG_MAX   = 7;              // largest magnitude, also the saturation bound

	// sign 1 means negative
	// a negative zero is legal on input and reads as plain zero
	typedef struct packed {
		logic                sign;
		logic [MAG_SIZE-1:0] mag;
	} msg_t;

endpackage

//--- row_pipe_pkg.sv
package row_pipe_pkg;

	import ldpc_msg_pkg::*;

	// row geometry
	localparam int CN_DEGREE = 10;            // messages per check row
	localparam int HALF_DEG  = CN_DEGREE / 2; // min search runs on two halves
	localparam int IDX_W     = 4;             // position index width

	// check node latency, row in to c2v out
	localparam int CNU_FUNC_CYCLE = 4;

	typedef msg_t [CN_DEGREE-1:0] row_msg_t;  // one full row, position 0 in the low bits
	typedef logic [CN_DEGREE-1:0] hd_vec_t;   // one hard decision per position

	// partial result of one half row
	typedef struct packed {
		logic [MAG_SIZE-1:0] min1;
		logic [MAG_SIZE-1:0] min2;     // equals min1 on a tie
		logic [IDX_W-1:0]    min1_idx; // row position, not half position
	} half_min_t;

	// everything the c2v stage needs from one row
	typedef struct packed {
		logic [MAG_SIZE-1:0]  min1;
		logic [MAG_SIZE-1:0]  min2;
		logic [IDX_W-1:0]     min1_idx;  // lowest position holding min1
		logic                 sign_prod; // xor of all signs
		logic [CN_DEGREE-1:0] signs;
	} min_pair_t;

endpackage

//--- row_process_element.f
+incdir+.
ldpc_msg_pkg.sv
row_pipe_pkg.sv
cnu_min_find.sv
cnu_c2v_gen.sv
v2c_delay_line.sv
vnu_app_update.sv
row_process_element.sv
tb_row_process_element.sv

//--- row_process_element.sv
`timescale 1ns/10ps

module row_process_element (
	input  logic                   read_clk,
	input  logic                   rstn,
	input  logic                   v2c_src,       // 1: ch_msg feeds the row, 0: v2c_in
	input  row_pipe_pkg::row_msg_t ch_msg,
	input  row_pipe_pkg::row_msg_t v2c_in,
	output row_pipe_pkg::row_msg_t cnu_c2v,       // k+3 for a row sampled at edge k
	output row_pipe_pkg::row_msg_t vnu_app,       // k+4
	output row_pipe_pkg::hd_vec_t  hard_decision  // k+4
);
	import row_pipe_pkg::*;

	row_msg_t  v2c_row;     // selected row, stage 1
	min_pair_t min_info;    // row minima, stage 3
	row_msg_t  v2c_aligned; // selected row delayed to meet its c2v

	// check node, first three stages
	cnu_min_find u_min_find (
		.read_clk (read_clk),
		.rstn     (rstn),
		.v2c_src  (v2c_src),
		.ch_msg   (ch_msg),
		.v2c_in   (v2c_in),
		.v2c_row  (v2c_row),
		.min_info (min_info)
	);

	// check node, last stage
	cnu_c2v_gen u_c2v_gen (
		.read_clk (read_clk),
		.rstn     (rstn),
		.min_info (min_info),
		.c2v      (cnu_c2v)
	);

	v2c_delay_line u_v2c_dly (
		.read_clk    (read_clk),
		.rstn        (rstn),
		.v2c_row     (v2c_row),
		.v2c_aligned (v2c_aligned)
	);

	// variable node, posterior and hard decision
	vnu_app_update u_vnu (
		.read_clk      (read_clk),
		.rstn          (rstn),
		.v2c_aligned   (v2c_aligned),
		.c2v           (cnu_c2v),
		.vnu_app       (vnu_app),
		.hard_decision (hard_decision)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_row_process_element \
	-f row_process_element.f -o tb_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1

//--- row_ref_model.svh
`ifndef ROW_REF_MODEL_SVH
`define ROW_REF_MODEL_SVH

// min-sum check node, done the slow way over the other nine positions
function automatic row_msg_t ref_c2v(input row_msg_t row);
	row_msg_t res;
	logic     s;
	int       m;
	for (int i = 0; i < CN_DEGREE; i++) begin
		s = 1'b0;
		m = MAG_MAX;
		for (int j = 0; j < CN_DEGREE; j++) begin
			if (j != i) begin
				s = s ^ row[j].sign;
				if (int'(row[j].mag) < m) m = int'(row[j].mag); // min of the others
			end
		end
		res[i].sign = s;
		res[i].mag  = MAG_SIZE'(m);
	end
	return res;
endfunction

// signed reading of one message, -0 gives 0
function automatic int msg_value(input msg_t x);
	return x.sign ? -int'(x.mag) : int'(x.mag);
endfunction

// v2c plus c2v, clamped to +-7
function automatic int post_sum(input msg_t v, input msg_t c);
	int s;
	s = msg_value(v) + msg_value(c);
	if (s > MAG_MAX) s = MAG_MAX;
	if (s < -MAG_MAX) s = -MAG_MAX;
	return s;
endfunction

function automatic row_msg_t ref_app(input row_msg_t v, input row_msg_t c);
	row_msg_t res;
	int       s;
	for (int i = 0; i < CN_DEGREE; i++) begin
		s           = post_sum(v[i], c[i]);
		res[i].sign = (s < 0); // a zero sum is always positive
		res[i].mag  = MAG_SIZE'((s < 0) ? -s : s);
	end
	return res;
endfunction

function automatic hd_vec_t ref_hd(input row_msg_t v, input row_msg_t c);
	hd_vec_t res;
	for (int i = 0; i < CN_DEGREE; i++) begin
		res[i] = (post_sum(v[i], c[i]) < 0);
	end
	return res;
endfunction

`endif

//--- tb_row_process_element.sv
`timescale 1ns/10ps

module tb_row_process_element;
	import ldpc_msg_pkg::*;
	import row_pipe_pkg::*;

	`include "row_ref_model.svh"

	localparam int RESET_CYCLES = 3;
	localparam int N_CHANNEL    = 500;
	localparam int N_DIRECTED   = 8;
	localparam int N_ALTERNATE  = 1000;
	localparam int N_DRAIN      = 5;  // last row needs 5 more edges to reach vnu_app
	localparam int MAX_CYCLES   = RESET_CYCLES + N_CHANNEL + N_DIRECTED + N_ALTERNATE
		+ N_DRAIN + 20;
	localparam logic [31:0] LFSR_TAPS = 32'ha300_0000;

	logic     read_clk;
	logic     rstn;
	logic     v2c_src;
	row_msg_t ch_msg;
	row_msg_t v2c_in;
	row_msg_t cnu_c2v;
	row_msg_t vnu_app;
	hd_vec_t  hard_decision;

	logic [31:0] lfsr_state;
	int          cycle_cnt;
	row_msg_t    hist_q[$]; // selected rows, oldest first
	string       name_q[$]; // test that applied each row

	row_process_element uut (
		.read_clk      (read_clk),
		.rstn          (rstn),
		.v2c_src       (v2c_src),
		.ch_msg        (ch_msg),
		.v2c_in        (v2c_in),
		.cnu_c2v       (cnu_c2v),
		.vnu_app       (vnu_app),
		.hard_decision (hard_decision)
	);

	always #10 read_clk = ~read_clk; // 20 ns period

	// run limit
	always @(posedge read_clk) begin
		cycle_cnt++;
		if (cycle_cnt > MAX_CYCLES) begin
			$display("timeout: the run went past %0d clock cycles", MAX_CYCLES);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r          = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return r;
	endfunction

	function automatic row_msg_t rand_row();
		row_msg_t             r;
		logic [QUAN_SIZE-1:0] b;
		for (int i = 0; i < CN_DEGREE; i++) begin
			b    = QUAN_SIZE'(rand_bits(QUAN_SIZE));
			r[i] = b;
		end
		return r;
	endfunction

	task automatic check_row(input string test, input row_msg_t exp, input row_msg_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %h actual %h", test, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "row mismatch in %s", test);
		end
	endtask

	task automatic check_hd(input string test, input hd_vec_t exp, input hd_vec_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %h actual %h", test, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "hard decision mismatch in %s", test);
		end
	endtask

	// check what is due this cycle, then drive the next row on the falling edge
	task automatic step_row(input string test, input logic src, input row_msg_t ch,
		input row_msg_t v2c);
		row_msg_t c_row; // row from 4 edges back
		row_msg_t a_row; // row from 5 edges back
		@(negedge read_clk);
		c_row = hist_q[$-3];
		a_row = hist_q[$-4];
		check_row({name_q[$-3], "/cnu_c2v"}, ref_c2v(c_row), cnu_c2v);
		check_row({name_q[$-4], "/vnu_app"}, ref_app(a_row, ref_c2v(a_row)), vnu_app);
		check_hd({name_q[$-4], "/hard_decision"}, ref_hd(a_row, ref_c2v(a_row)),
			hard_decision);
		v2c_src = src;
		ch_msg  = ch;
		v2c_in  = v2c;
		hist_q.push_back(src ? ch : v2c); // the row the DUT will pick
		name_q.push_back(test);
		if (hist_q.size() > 6) begin
			void'(hist_q.pop_front());
			void'(name_q.pop_front());
		end
	endtask

	// directed row on the v2c port, channel holds its inverse as a decoy
	task automatic step_directed(input string test, input row_msg_t row);
		step_row(test, 1'b0, ~row, row);
	endtask

	initial begin
		read_clk   = 1'b0;
		rstn       = 1'b0;
		v2c_src    = 1'b0;
		ch_msg     = '0;
		v2c_in     = '0;
		cycle_cnt  = 0;
		lfsr_state = 32'he4e9;
		// pipeline is all zero coming out of reset
		for (int i = 0; i < 5; i++) begin
			hist_q.push_back('0);
			name_q.push_back("reset");
		end

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge read_clk);
			check_row("reset/cnu_c2v", '0, cnu_c2v);
			check_row("reset/vnu_app", '0, vnu_app);
			check_hd("reset/hard_decision", '0, hard_decision);
		end
		rstn = 1'b1; // released on the third falling edge

		// channel source only
		for (int i = 0; i < N_CHANNEL; i++) begin
			step_row("channel", 1'b1, rand_row(), rand_row());
		end

		// tied minima, position 9 is the leftmost digit
		step_directed("tied_minima", 40'h62f3_57a2_c4);   // three at 2
		step_directed("tied_minima", 40'h3561_7247_9c);   // 1 in both halves
		step_directed("tied_minima", 40'h0580_6380_27);   // zeros, some negative
		step_directed("tied_minima", 40'h4c4c_44cc_4c);   // all magnitude 4
		step_directed("saturation", 40'h7777_7777_77);    // +7 + +7
		step_directed("saturation", 40'hffff_ffff_ff);    // -7 + -7
		step_directed("negative_zero", 40'h8888_8888_88); // -0 meets -0
		step_directed("negative_zero", 40'h8080_8080_80);

		// source picked at random each cycle
		for (int i = 0; i < N_ALTERNATE; i++) begin
			step_row("alternating", 1'(rand_bits(1)), rand_row(), rand_row());
		end

		// flush the last rows out
		for (int i = 0; i < N_DRAIN; i++) begin
			step_row("drain", 1'b1, '0, '0);
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- v2c_delay_line.sv
`timescale 1ns/10ps

module v2c_delay_line (
	input  logic                   read_clk,
	input  logic                   rstn,
	input  row_pipe_pkg::row_msg_t v2c_row,     // already one stage past the input
	output row_pipe_pkg::row_msg_t v2c_aligned  // lines up with the c2v register
);
	import row_pipe_pkg::*;

	// v2c_row is stage 1 of the check node, so CNU_FUNC_CYCLE-1 more stages remain
	localparam int DLY = CNU_FUNC_CYCLE - 1;

	row_msg_t pipe_q [0:DLY-1]; // up to three rows in flight

	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			for (int i = 0; i < DLY; i++) begin
				pipe_q[i] <= '0;
			end
		end else begin
			pipe_q[0] <= v2c_row;
			for (int i = 1; i < DLY; i++) begin
				pipe_q[i] <= pipe_q[i-1]; // plain shift, nothing stalls
			end
		end
	end

	assign v2c_aligned = pipe_q[DLY-1];

endmodule

//--- vnu_app_update.sv
`timescale 1ns/10ps

module vnu_app_update (
	input  logic                   read_clk,
	input  logic                   rstn,
	input  row_pipe_pkg::row_msg_t v2c_aligned,
	input  row_pipe_pkg::row_msg_t c2v,
	output row_pipe_pkg::row_msg_t vnu_app,       // posterior, sign-magnitude
	output row_pipe_pkg::hd_vec_t  hard_decision  // 1 where the posterior is negative
);
	import ldpc_msg_pkg::*;
	import row_pipe_pkg::*;

	// sign-magnitude to two's complement, one extra bit so the sum of two fits
	function automatic logic signed [QUAN_SIZE:0] to_signed(input msg_t m);
		logic signed [QUAN_SIZE:0] v;
		v = $signed((QUAN_SIZE+1)'(m.mag));
		return m.sign ? -v : v; // negative zero folds to 0 here
	endfunction

	// add, clamp to +-MAG_MAX, back to sign-magnitude
	function automatic msg_t app_sum(input msg_t v, input msg_t c);
		logic signed [QUAN_SIZE:0] sum;
		msg_t                      res;
		sum = to_signed(v) + to_signed(c); // -14..14
		if (sum > MAG_MAX) begin
			sum = (QUAN_SIZE+1)'(MAG_MAX);
		end else if (sum < -MAG_MAX) begin
			sum = -(QUAN_SIZE+1)'(MAG_MAX);
		end
		res.sign = sum[QUAN_SIZE]; // only a true negative, zero stays positive
		res.mag  = res.sign ? MAG_SIZE'(-sum) : MAG_SIZE'(sum);
		return res;
	endfunction

	row_msg_t app_d;
	hd_vec_t  hd_d;

	always_comb begin
		for (int i = 0; i < CN_DEGREE; i++) begin
			app_d[i] = app_sum(v2c_aligned[i], c2v[i]);
			hd_d[i]  = app_d[i].sign; // hard decision is just the posterior sign
		end
	end

	// stage 5 counted from the row input
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			vnu_app       <= '0;
			hard_decision <= '0;
		end else begin
			vnu_app       <= app_d;
			hard_decision <= hd_d;
		end
	end

endmodule
